// File: mem_subsys.f
+incdir+verification
src/mem_pkg.sv
src/mem_handler.sv
src/pc_unit.sv
src/store_align.sv
src/load_extend.sv
src/data_ram.sv
src/mem_subsys_top.sv
verification/tb_mem_subsys.sv

// File: src/data_ram.sv
/*
 * unified instruction and data RAM on the internal request/done bus
 * word addressed, byte-lane writes, done after ram_wait extra cycles
 */
`timescale 1ns/1ps

module data_ram #(
    parameter int ram_words = 256,
    parameter int ram_wait  = 2
) (
    input  logic                      clk,
    input  logic                      nrst,
    input  logic                      bus_read,
    input  logic                      bus_write,
    input  logic [mem_pkg::xlen-1:0]  bus_addr,
    input  logic [mem_pkg::xlen-1:0]  bus_wdata,
    input  mem_pkg::byte_sel_t        bus_sel,
    output logic [mem_pkg::xlen-1:0]  bus_rdata,
    output logic                      bus_done
);

    localparam int idx_w = (ram_words > 1) ? $clog2(ram_words) : 1;

    logic [mem_pkg::xlen-1:0] mem [ram_words];
    logic [idx_w-1:0]         word_idx;
    // cycles the current request has waited
    logic [2:0]               wait_cnt;
    logic                     req;
    logic                     accept;

    assign req = bus_read | bus_write;

    // byte address to word index, wraps at ram_words
    assign word_idx = idx_w'(bus_addr[mem_pkg::xlen-1:2] % ram_words);

    // done in the (ram_wait+1)th cycle of the request
    assign bus_done = req & (wait_cnt == 3'(ram_wait));

    // request masked by done, a held level never opens a second access
    assign accept = req & ~bus_done;

    // read word, sampled by the handler with done
    assign bus_rdata = mem[word_idx];

    always_ff @(posedge clk, negedge nrst) begin
        if (!nrst) begin
            wait_cnt <= '0;
        end else if (bus_done) begin
            wait_cnt <= '0;
        end else if (accept) begin
            wait_cnt <= wait_cnt + 3'd1;
        end
    end

    // storage, zero after reset, lanes written at done
    always_ff @(posedge clk, negedge nrst) begin
        if (!nrst) begin
            for (int i = 0; i < ram_words; i++) begin
                mem[i] <= '0;
            end
        end else if (bus_done && bus_write) begin
            for (int b = 0; b < 4; b++) begin
                if (bus_sel[b]) begin
                    mem[word_idx][8*b +: 8] <= bus_wdata[8*b +: 8];
                end
            end
        end
    end

    // requester holds its level until done
    a_req_held: assert property (@(posedge clk) disable iff (!nrst)
        (req && !bus_done) |=> req);

    // and keeps the address steady meanwhile
    a_addr_held: assert property (@(posedge clk) disable iff (!nrst)
        (req && !bus_done) |=> $stable(bus_addr));

endmodule

// File: src/load_extend.sv
/*
 * load data extraction for LB, LH, LW, LBU and LHU
 * picks the addressed byte or half from the read word and extends it,
 * purely combinational, the handler registers the result
 */
`timescale 1ns/1ps

module load_extend (
    input  mem_pkg::func3_t           func3,
    input  logic [1:0]                byte_offset,
    input  logic [mem_pkg::xlen-1:0]  rdata,
    output logic [mem_pkg::xlen-1:0]  ext_data
);

    logic [7:0]  lane_byte;
    logic [15:0] lane_half;

    // byte by full offset
    assign lane_byte = rdata[8*byte_offset +: 8];

    // half by offset bit 1, bit 0 ignored
    assign lane_half = byte_offset[1] ? rdata[31:16] : rdata[15:0];

    always_comb begin
        case (func3)
            mem_pkg::f3_b: begin
                ext_data = {{24{lane_byte[7]}}, lane_byte};
            end
            mem_pkg::f3_h: begin
                ext_data = {{16{lane_half[15]}}, lane_half};
            end
            mem_pkg::f3_bu: begin
                ext_data = {24'b0, lane_byte};
            end
            mem_pkg::f3_hu: begin
                ext_data = {16'b0, lane_half};
            end
            default: begin
                // word, unchanged
                ext_data = rdata;
            end
        endcase
    end

endmodule

// File: src/mem_handler.sv
/*
 * control FSM of the memory-access unit
 * fetches one instruction at pc, then runs one load, store, branch or
 * plain step for it and advances the program counter
 */
`timescale 1ns/1ps

module mem_handler (
    input  logic                      clk,
    input  logic                      nrst,
    // core side, valid while instr_valid, held until op_done
    input  logic                      read,
    input  logic                      write,
    input  logic                      branch,
    input  mem_pkg::func3_t           func3,
    input  logic [mem_pkg::xlen-1:0]  mem_address,
    input  logic [mem_pkg::xlen-1:0]  pc,
    // ram side
    input  logic [mem_pkg::xlen-1:0]  bus_rdata,
    input  logic                      bus_done,
    // extended load value from load_extend
    input  logic [mem_pkg::xlen-1:0]  ext_data,
    output logic                      bus_read,
    output logic                      bus_write,
    output logic [mem_pkg::xlen-1:0]  bus_addr,
    output logic [mem_pkg::xlen-1:0]  instruction,
    output logic [mem_pkg::xlen-1:0]  load_data,
    output logic                      instr_valid,
    output logic                      load_valid,
    output logic                      op_done,
    output logic                      store_capture,
    output logic                      pc_advance,
    output logic                      pc_load
);

    mem_pkg::hstate_t state, next_state;

    // request levels, held until the ram answers
    logic read_q;
    logic write_q;
    // step kind seen in lors, used at inc
    logic br_q;

    // next state
    always_comb begin
        next_state = state;
        case (state)
            mem_pkg::inc: begin
                next_state = mem_pkg::wait_step;
            end
            mem_pkg::wait_step: begin
                next_state = mem_pkg::fetch;
            end
            mem_pkg::fetch: begin
                next_state = mem_pkg::fwait;
            end
            mem_pkg::fwait: begin
                if (bus_done) begin
                    next_state = mem_pkg::lors;
                end
            end
            mem_pkg::lors: begin
                // neither load nor store goes straight to the pc update
                if (read || write) begin
                    next_state = mem_pkg::lwait;
                end else begin
                    next_state = mem_pkg::inc;
                end
            end
            mem_pkg::lwait: begin
                if (bus_done) begin
                    next_state = read_q ? mem_pkg::regop : mem_pkg::inc;
                end
            end
            mem_pkg::regop: begin
                next_state = mem_pkg::inc;
            end
            default: begin
                next_state = mem_pkg::fetch;
            end
        endcase
    end

    // control registers
    always_ff @(posedge clk, negedge nrst) begin
        if (!nrst) begin
            state   <= mem_pkg::fetch;
            read_q  <= 1'b0;
            write_q <= 1'b0;
            br_q    <= 1'b0;
        end else begin
            state <= next_state;
            if (bus_done) begin
                // request drops the cycle after done
                read_q  <= 1'b0;
                write_q <= 1'b0;
            end else if (state == mem_pkg::fetch) begin
                read_q <= 1'b1;
            end else if (state == mem_pkg::lors) begin
                // load wins if the core raises both
                read_q  <= read;
                write_q <= write & ~read;
            end
            if (state == mem_pkg::lors) begin
                br_q <= branch & ~read & ~write;
            end
        end
    end

    // address, instruction and load value
    always_ff @(posedge clk) begin
        if (state == mem_pkg::fetch) begin
            bus_addr <= pc;
        end else if (state == mem_pkg::lors) begin
            bus_addr <= mem_address;
        end
        if (state == mem_pkg::fwait && bus_done) begin
            instruction <= bus_rdata;
        end
        if (state == mem_pkg::lwait && bus_done && read_q) begin
            load_data <= ext_data;
        end
    end

    assign bus_read  = read_q;
    assign bus_write = write_q;

    // core-facing markers, decoded from state
    assign instr_valid = (state == mem_pkg::lors);
    assign load_valid  = (state == mem_pkg::regop);
    assign op_done     = (state == mem_pkg::inc);

    // store data is formatted as the store leaves lors
    assign store_capture = (state == mem_pkg::lors) & write & ~read;

    // pc moves once per step, at inc
    assign pc_load    = (state == mem_pkg::inc) & br_q;
    assign pc_advance = (state == mem_pkg::inc) & ~br_q;

    // one access direction at a time on the ram bus
    a_one_dir: assert property (@(posedge clk) disable iff (!nrst)
        !(bus_read && bus_write));

    // reads only while waiting on fetch or load data
    a_read_state: assert property (@(posedge clk) disable iff (!nrst)
        bus_read |-> (state == mem_pkg::fwait || state == mem_pkg::lwait));

    // core keeps func3 and address steady through the data access
    a_core_hold: assert property (@(posedge clk) disable iff (!nrst)
        (state == mem_pkg::lwait) |-> ($stable(func3) && $stable(mem_address)));

endmodule

// File: src/mem_pkg.sv
/*
 * shared constants and types for the memory-access subsystem
 * func3 load/store codes, handler state encoding and bus widths
 * referenced by scoped name from every RTL file
 */

package mem_pkg;

    // data and address width, one word
    localparam int xlen = 32;

    // func3 field of load and store instructions
    typedef logic [2:0] func3_t;

    // signed byte, half, word
    localparam func3_t f3_b  = 3'd0;
    localparam func3_t f3_h  = 3'd1;
    localparam func3_t f3_w  = 3'd2;
    // unsigned byte and half, loads only
    localparam func3_t f3_bu = 3'd4;
    localparam func3_t f3_hu = 3'd5;

    // handler sequence per instruction step
    // fetch -> fwait -> lors -> (lwait -> (regop)) -> inc -> wait_step
    typedef enum logic [2:0] {
        inc,
        wait_step,
        fetch,
        fwait,
        lors,
        lwait,
        regop
    } hstate_t;

    // one bit per byte lane, bit 0 is the low byte
    typedef logic [3:0] byte_sel_t;

endpackage

// File: src/mem_subsys_top.sv
/*
 * memory-access subsystem top level
 * the core drives one load, store or branch per fetched instruction
 * between instr_valid and op_done
 */
`timescale 1ns/1ps

module mem_subsys_top #(
    parameter int                       ram_words = 256,
    parameter int                       ram_wait  = 2,
    parameter logic [mem_pkg::xlen-1:0] reset_pc  = '0
) (
    input  logic                      clk,
    input  logic                      nrst,
    input  logic                      read,
    input  logic                      write,
    input  logic                      branch,
    input  mem_pkg::func3_t           func3,
    input  logic [mem_pkg::xlen-1:0]  mem_address,
    input  logic [mem_pkg::xlen-1:0]  store_data,
    input  logic [mem_pkg::xlen-1:0]  branch_target,
    output logic [mem_pkg::xlen-1:0]  instruction,
    output logic [mem_pkg::xlen-1:0]  pc,
    output logic [mem_pkg::xlen-1:0]  load_data,
    output logic                      instr_valid,
    output logic                      load_valid,
    output logic                      op_done
);

    // internal ram bus
    logic                      bus_read;
    logic                      bus_write;
    logic [mem_pkg::xlen-1:0]  bus_addr;
    logic [mem_pkg::xlen-1:0]  bus_wdata;
    mem_pkg::byte_sel_t        bus_sel;
    logic [mem_pkg::xlen-1:0]  bus_rdata;
    logic                      bus_done;

    // handler strobes and load path
    logic                      store_capture;
    logic                      pc_advance;
    logic                      pc_load;
    logic [mem_pkg::xlen-1:0]  ext_data;

    mem_handler u_handler (
        .clk           (clk),
        .nrst          (nrst),
        .read          (read),
        .write         (write),
        .branch        (branch),
        .func3         (func3),
        .mem_address   (mem_address),
        .pc            (pc),
        .bus_rdata     (bus_rdata),
        .bus_done      (bus_done),
        .ext_data      (ext_data),
        .bus_read      (bus_read),
        .bus_write     (bus_write),
        .bus_addr      (bus_addr),
        .instruction   (instruction),
        .load_data     (load_data),
        .instr_valid   (instr_valid),
        .load_valid    (load_valid),
        .op_done       (op_done),
        .store_capture (store_capture),
        .pc_advance    (pc_advance),
        .pc_load       (pc_load)
    );

    pc_unit #(
        .reset_pc (reset_pc)
    ) u_pc (
        .clk     (clk),
        .nrst    (nrst),
        .advance (pc_advance),
        .load    (pc_load),
        .target  (branch_target),
        .pc      (pc)
    );

    // byte offset straight from the held core address
    store_align u_store (
        .clk         (clk),
        .nrst        (nrst),
        .capture     (store_capture),
        .func3       (func3),
        .byte_offset (mem_address[1:0]),
        .store_data  (store_data),
        .bus_wdata   (bus_wdata),
        .bus_sel     (bus_sel)
    );

    load_extend u_load (
        .func3       (func3),
        .byte_offset (mem_address[1:0]),
        .rdata       (bus_rdata),
        .ext_data    (ext_data)
    );

    data_ram #(
        .ram_words (ram_words),
        .ram_wait  (ram_wait)
    ) u_ram (
        .clk       (clk),
        .nrst      (nrst),
        .bus_read  (bus_read),
        .bus_write (bus_write),
        .bus_addr  (bus_addr),
        .bus_wdata (bus_wdata),
        .bus_sel   (bus_sel),
        .bus_rdata (bus_rdata),
        .bus_done  (bus_done)
    );

endmodule

// File: src/pc_unit.sv
/*
 * program counter register
 * steps by one word on advance, or takes the branch target on load
 */
`timescale 1ns/1ps

module pc_unit #(
    parameter logic [mem_pkg::xlen-1:0] reset_pc = '0
) (
    input  logic                      clk,
    input  logic                      nrst,
    input  logic                      advance,
    input  logic                      load,
    input  logic [mem_pkg::xlen-1:0]  target,
    output logic [mem_pkg::xlen-1:0]  pc
);

    // next word address
    logic [mem_pkg::xlen-1:0] pc_next_word;

    assign pc_next_word = pc + mem_pkg::xlen'(4);

    always_ff @(posedge clk, negedge nrst) begin
        if (!nrst) begin
            pc <= reset_pc;
        end else if (load) begin
            // branch target forced onto a word boundary
            pc <= {target[mem_pkg::xlen-1:2], 2'b00};
        end else if (advance) begin
            pc <= pc_next_word;
        end
    end

    // fetch address never lands inside a word, reset_pc included
    a_pc_aligned: assert property (@(posedge clk) disable iff (!nrst)
        pc[1:0] == 2'b00);

endmodule

// File: src/store_align.sv
/*
 * store formatter for SB, SH and SW
 * replicates the store data into byte lanes and builds the byte selects,
 * registered on capture so both are ready with the write request
 */
`timescale 1ns/1ps

module store_align (
    input  logic                      clk,
    input  logic                      nrst,
    input  logic                      capture,
    input  mem_pkg::func3_t           func3,
    input  logic [1:0]                byte_offset,
    input  logic [mem_pkg::xlen-1:0]  store_data,
    output logic [mem_pkg::xlen-1:0]  bus_wdata,
    output mem_pkg::byte_sel_t        bus_sel
);

    // lane selects, cleared at reset
    always_ff @(posedge clk, negedge nrst) begin
        if (!nrst) begin
            bus_sel <= '0;
        end else if (capture) begin
            case (func3)
                mem_pkg::f3_b: bus_sel <= 4'b0001 << byte_offset;
                // half lands in the low or high pair
                mem_pkg::f3_h: bus_sel <= byte_offset[1] ? 4'b1100 : 4'b0011;
                mem_pkg::f3_w: bus_sel <= 4'b1111;
                // not a store width, nothing written
                default:       bus_sel <= 4'b0000;
            endcase
        end
    end

    // lane data, every lane carries a copy
    always_ff @(posedge clk) begin
        if (capture) begin
            case (func3)
                mem_pkg::f3_b: bus_wdata <= {4{store_data[7:0]}};
                mem_pkg::f3_h: bus_wdata <= {2{store_data[15:0]}};
                default:       bus_wdata <= store_data;
            endcase
        end
    end

endmodule

// File: verification/tb_ref_model.svh
/*
 * reference model for the memory-access testbench, included in the module
 * shadow word memory with store lanes, load extension, fetch word, next pc
 */
`ifndef TB_REF_MODEL_SVH
`define TB_REF_MODEL_SVH

// shadow of the unified ram, one entry per word
logic [31:0] shadow_mem [ram_words];
// pc the core should see at the next instr_valid
logic [31:0] model_pc;

// byte address to word entry, wraps at the ram size
function automatic int word_index(input logic [31:0] addr);
    return int'((addr >> 2) % ram_words);
endfunction

function automatic void clear_shadow();
    for (int i = 0; i < ram_words; i++) begin
        shadow_mem[i] = '0;
    end
endfunction

// only the lanes named by width and offset change
function automatic void shadow_write(input mem_pkg::func3_t f3, input logic [31:0] addr,
                                     input logic [31:0] data);
    int idx;
    idx = word_index(addr);
    case (f3)
        mem_pkg::f3_b: shadow_mem[idx][8*addr[1:0] +: 8] = data[7:0];
        // half goes low or high by address bit 1
        mem_pkg::f3_h: shadow_mem[idx][16*addr[1] +: 16] = data[15:0];
        default:       shadow_mem[idx] = data;
    endcase
endfunction

function automatic logic [31:0] expect_load(input mem_pkg::func3_t f3,
                                            input logic [31:0] addr);
    logic [31:0] word;
    logic [7:0]  lane_b;
    logic [15:0] lane_h;
    word   = shadow_mem[word_index(addr)];
    lane_b = word[8*addr[1:0] +: 8];
    lane_h = word[16*addr[1] +: 16];
    case (f3)
        mem_pkg::f3_b:  return 32'($signed(lane_b));
        mem_pkg::f3_h:  return 32'($signed(lane_h));
        mem_pkg::f3_bu: return {24'h0, lane_b};
        mem_pkg::f3_hu: return {16'h0, lane_h};
        default:        return word;
    endcase
endfunction

function automatic logic [31:0] expect_instr(input logic [31:0] addr);
    return shadow_mem[word_index(addr)];
endfunction

// branch target lands on its word, everything else steps one word
function automatic logic [31:0] pc_after(input logic [31:0] cur, input logic take,
                                         input logic [31:0] target);
    return take ? {target[31:2], 2'b00} : cur + 32'd4;
endfunction

`endif

// File: verification/tb_mem_subsys.sv
/*
 * testbench for the memory-access subsystem
 * plays the core: answers each instr_valid with a load, store, branch or
 * plain step and checks fetch, load data and pc against the model
 */
`timescale 1ns/1ps

module tb_mem_subsys;

    localparam int          ram_words    = 256;
    localparam int          ram_wait     = 2;
    localparam logic [31:0] reset_pc     = '0;
    localparam int          reset_cycles = 16;
    localparam int          idx_bits     = $clog2(ram_words);
    // sw/lw 2, byte lanes 16, half lanes 8, plain 2, branch 3
    localparam int          n_directed   = 31;
    localparam int          n_random     = 400;
    // longest step is 2*(ram_wait+1)+5 cycles, some margin on top
    localparam int          timeout_cycles = reset_cycles
                                + (n_directed + n_random) * (2 * (ram_wait + 1) + 8);

    logic            clk;
    logic            nrst;
    logic            read;
    logic            write;
    logic            branch;
    mem_pkg::func3_t func3;
    logic [31:0]     mem_address;
    logic [31:0]     store_data;
    logic [31:0]     branch_target;
    logic [31:0]     instruction;
    logic [31:0]     pc;
    logic [31:0]     load_data;
    logic            instr_valid;
    logic            load_valid;
    logic            op_done;

    logic [31:0]     lfsr = 32'd75843;
    int              cycle_count = 0;

    `include "tb_ref_model.svh"

    mem_subsys_top #(
        .ram_words (ram_words),
        .ram_wait  (ram_wait),
        .reset_pc  (reset_pc)
    ) UUT (
        .clk           (clk),
        .nrst          (nrst),
        .read          (read),
        .write         (write),
        .branch        (branch),
        .func3         (func3),
        .mem_address   (mem_address),
        .store_data    (store_data),
        .branch_target (branch_target),
        .instruction   (instruction),
        .pc            (pc),
        .load_data     (load_data),
        .instr_valid   (instr_valid),
        .load_valid    (load_valid),
        .op_done       (op_done)
    );

    always #50 clk = ~clk;

    // run limit
    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= timeout_cycles) begin
            $display("timeout: the run did not finish within %0d cycles", timeout_cycles);
            $display("Something failed");
            $fatal(1, "run stopped by cycle limit");
        end
    end

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    // one lfsr step per bit, first bit ends up as msb
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);
            v = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] expected);
        if (got !== expected) begin
            $display("error at %0t ns: %s, got %h expected %h", $time, what, got, expected);
            $display("Something failed");
            $fatal(1, "stopped at first mismatch");
        end
    endtask

    // sample point, outputs settled and inputs safe to change
    task automatic wait_cycle();
        @(posedge clk);
        #5;
    endtask

    // one full handler step as seen from the core
    task automatic run_step(input logic rd, input logic wr, input logic br,
                            input mem_pkg::func3_t f3, input logic [31:0] addr,
                            input logic [31:0] wdata, input logic [31:0] target);
        int          load_pulses;
        logic [31:0] exp_load;
        load_pulses = 0;
        exp_load    = expect_load(f3, addr);
        do begin
            wait_cycle();
        end while (!instr_valid);
        // also covers the zero word on the first fetch after reset
        check_value("pc at instr_valid", pc, model_pc);
        check_value("fetched instruction", instruction, expect_instr(model_pc));
        read          = rd;
        write         = wr;
        branch        = br;
        func3         = f3;
        mem_address   = addr;
        store_data    = wdata;
        branch_target = target;
        do begin
            wait_cycle();
            if (load_valid) begin
                load_pulses++;
                check_value("load data", load_data, exp_load);
            end
        end while (!op_done);
        check_value("load_valid pulses in step", 32'(load_pulses), {31'b0, rd});
        if (wr) begin
            shadow_write(f3, addr, wdata);
        end
        model_pc = pc_after(model_pc, br & ~rd & ~wr, target);
        read   = 1'b0;
        write  = 1'b0;
        branch = 1'b0;
    endtask

    task automatic do_store(input mem_pkg::func3_t f3, input logic [31:0] addr,
                            input logic [31:0] data);
        run_step(1'b0, 1'b1, 1'b0, f3, addr, data, '0);
    endtask

    task automatic do_load(input mem_pkg::func3_t f3, input logic [31:0] addr);
        run_step(1'b1, 1'b0, 1'b0, f3, addr, '0, '0);
    endtask

    task automatic do_plain();
        run_step(1'b0, 1'b0, 1'b0, mem_pkg::f3_w, '0, '0, '0);
    endtask

    // random kind, width and legal offset inside the ram
    task automatic random_step();
        logic [1:0]      kind;
        logic [2:0]      idx;
        mem_pkg::func3_t f3;
        logic [31:0]     addr;
        logic [31:0]     data;
        kind = take_bits(2);
        addr = take_bits(idx_bits) << 2;
        data = take_bits(32);
        if (kind == 2'd0) begin
            idx = take_bits(3) % 5;
            f3  = (idx < 3) ? idx : idx + 3'd1;
        end else begin
            f3 = take_bits(2) % 3;
        end
        case (f3)
            mem_pkg::f3_b, mem_pkg::f3_bu: addr[1:0] = take_bits(2);
            mem_pkg::f3_h, mem_pkg::f3_hu: addr[1]   = take_bits(1);
            default: ;
        endcase
        case (kind)
            2'd0: do_load(f3, addr);
            2'd1: do_store(f3, addr, data);
            2'd2: run_step(1'b0, 1'b0, 1'b1, f3, '0, '0, take_bits(idx_bits + 2));
            default: do_plain();
        endcase
    endtask

    initial begin
        logic [31:0] base;
        clk           = 1'b0;
        nrst          = 1'b0;
        read          = 1'b0;
        write         = 1'b0;
        branch        = 1'b0;
        func3         = mem_pkg::f3_w;
        mem_address   = '0;
        store_data    = '0;
        branch_target = '0;
        clear_shadow();
        model_pc = reset_pc;
        repeat (reset_cycles) @(posedge clk);
        #5;
        nrst = 1'b1;
        check_value("pc after reset", pc, reset_pc);
        check_value("load_valid after reset", {31'b0, load_valid}, '0);
        check_value("op_done after reset", {31'b0, op_done}, '0);
        check_value("instr_valid after reset", {31'b0, instr_valid}, '0);

        // word store and read back
        base = take_bits(idx_bits) << 2;
        do_store(mem_pkg::f3_w, base, take_bits(32));
        do_load(mem_pkg::f3_w, base);

        // byte lanes, signed and unsigned views
        base = take_bits(idx_bits) << 2;
        for (int off = 0; off < 4; off++) begin
            do_store(mem_pkg::f3_b, base + off, take_bits(32));
            do_load(mem_pkg::f3_b, base + off);
            do_load(mem_pkg::f3_bu, base + off);
            do_load(mem_pkg::f3_w, base);
        end

        // low and high half
        base = take_bits(idx_bits) << 2;
        for (int off = 0; off < 4; off += 2) begin
            do_store(mem_pkg::f3_h, base + off, take_bits(32));
            do_load(mem_pkg::f3_h, base + off);
            do_load(mem_pkg::f3_hu, base + off);
            do_load(mem_pkg::f3_w, base);
        end

        do_plain();
        do_plain();

        // branch to a marked word, unaligned target on purpose
        base = take_bits(idx_bits) << 2;
        do_store(mem_pkg::f3_w, base, take_bits(32));
        run_step(1'b0, 1'b0, 1'b1, mem_pkg::f3_w, '0, '0, base | 32'd2);
        do_plain();

        for (int i = 0; i < n_random; i++) begin
            random_step();
        end

        $display("Everything OK");
        $finish;
    end

endmodule
